//--- rtl/exec_pkg.sv
package exec_pkg;

	localparam int data_width = 32;                                // Word and register width
	localparam int reg_addr_width = 5;                             // Register index width
	localparam int imm_width = 16;                                 // I-type immediate field
	localparam logic [reg_addr_width-1:0] link_reg = 5'd31;        // BGEZAL destination

	// REGIMM sub-codes carried in the rt field
	localparam logic [reg_addr_width-1:0] regimm_bgez = 5'b00000;
	localparam logic [reg_addr_width-1:0] regimm_bgezal = 5'b10001;

	typedef enum logic [3:0] {
		alu_and     = 4'b0000,
		alu_or      = 4'b0001,
		alu_add     = 4'b0010,
		alu_addu    = 4'b0011,
		alu_sub     = 4'b0110,  // Also BEQ/BNE compare
		alu_subu    = 4'b0111,
		alu_bgez    = 4'b1000,
		alu_slt     = 4'b1001,
		alu_nor     = 4'b1100,
		alu_xor     = 4'b1101,
		alu_illegal = 4'b1110,  // Falls to the deadbeef result
		alu_lui     = 4'b1111
	} alu_op_t;

	typedef enum logic [5:0] {
		op_special = 6'b000000,
		op_regimm  = 6'b000001,
		op_beq     = 6'b000100,
		op_bne     = 6'b000101,
		op_addi    = 6'b001000,
		op_addiu   = 6'b001001,
		op_slti    = 6'b001010,
		op_andi    = 6'b001100,
		op_ori     = 6'b001101,
		op_xori    = 6'b001110,
		op_lui     = 6'b001111
	} opcode_t;

	typedef enum logic [5:0] {
		fn_add  = 6'b100000,
		fn_addu = 6'b100001,
		fn_sub  = 6'b100010,
		fn_subu = 6'b100011,
		fn_and  = 6'b100100,
		fn_or   = 6'b100101,
		fn_xor  = 6'b100110,
		fn_nor  = 6'b100111,
		fn_slt  = 6'b101010
	} funct_t;

	typedef enum logic [1:0] {
		ext_sign  = 2'b00,
		ext_zero  = 2'b01,
		ext_upper = 2'b10
	} ext_mode_t;

	typedef enum logic [1:0] {
		br_none      = 2'b00,
		br_cond      = 2'b01,  // BEQ, BNE, BGEZ
		br_cond_link = 2'b10   // BGEZAL
	} branch_kind_t;

endpackage

//--- rtl/exec_control.sv
`timescale 1ns/100ps

module exec_control (
	input  logic [31:0]             instr,
	output exec_pkg::alu_op_t       alu_op,
	output logic                    use_imm,
	output exec_pkg::ext_mode_t     ext_mode,
	output exec_pkg::branch_kind_t  branch_kind,
	output logic                    equal,
	output logic                    dest_is_rt,
	output logic                    write_en_dec,
	output logic                    illegal
);
	import exec_pkg::*;

	opcode_t opcode;
	funct_t funct;
	logic [reg_addr_width-1:0] rt_field;

	assign opcode = opcode_t'(instr[31:26]);
	assign funct = funct_t'(instr[5:0]);
	assign rt_field = instr[20:16];  // REGIMM selector

	always_comb begin
		alu_op = alu_illegal;  // Unknown until decoded
		use_imm = 1'b0;
		ext_mode = ext_sign;
		branch_kind = br_none;
		equal = 1'b1;
		dest_is_rt = 1'b0;
		write_en_dec = 1'b0;
		illegal = 1'b0;
		case (opcode)
			op_special: begin
				write_en_dec = 1'b1;  // R-type writes rd
				case (funct)
					fn_add:  alu_op = alu_add;
					fn_addu: alu_op = alu_addu;
					fn_sub:  alu_op = alu_sub;
					fn_subu: alu_op = alu_subu;
					fn_and:  alu_op = alu_and;
					fn_or:   alu_op = alu_or;
					fn_xor:  alu_op = alu_xor;
					fn_nor:  alu_op = alu_nor;
					fn_slt:  alu_op = alu_slt;
					default: begin
						write_en_dec = 1'b0;
						illegal = 1'b1;
					end
				endcase
			end
			op_regimm: begin
				alu_op = alu_bgez;  // rs >= 0 test
				if (rt_field == regimm_bgez) begin
					branch_kind = br_cond;
				end else if (rt_field == regimm_bgezal) begin
					branch_kind = br_cond_link;
					write_en_dec = 1'b1;  // Link written even if not taken
				end else begin
					alu_op = alu_illegal;
					illegal = 1'b1;
				end
			end
			op_beq, op_bne: begin
				alu_op = alu_sub;  // Compare rs with rt
				branch_kind = br_cond;
				equal = (opcode == op_beq);
			end
			op_addi, op_addiu, op_slti: begin
				use_imm = 1'b1;
				dest_is_rt = 1'b1;
				write_en_dec = 1'b1;
				if (opcode == op_addi)
					alu_op = alu_add;  // Wraps, no trap
				else if (opcode == op_addiu)
					alu_op = alu_addu;
				else
					alu_op = alu_slt;
			end
			op_andi, op_ori, op_xori: begin
				use_imm = 1'b1;
				ext_mode = ext_zero;  // Logic immediates are unsigned
				dest_is_rt = 1'b1;
				write_en_dec = 1'b1;
				if (opcode == op_andi)
					alu_op = alu_and;
				else if (opcode == op_ori)
					alu_op = alu_or;
				else
					alu_op = alu_xor;
			end
			op_lui: begin
				alu_op = alu_lui;
				use_imm = 1'b1;
				ext_mode = ext_upper;
				dest_is_rt = 1'b1;
				write_en_dec = 1'b1;
			end
			default: illegal = 1'b1;  // No write, no branch
		endcase
	end

endmodule

//--- rtl/operand_extend.sv
`timescale 1ns/100ps

module operand_extend (
	input  logic [31:0]                     instr,
	input  logic [exec_pkg::data_width-1:0] rt_value,
	input  exec_pkg::ext_mode_t             ext_mode,
	input  logic                            use_imm,
	output logic [exec_pkg::data_width-1:0] imm_value,
	output logic [exec_pkg::data_width-1:0] operand_b
);
	import exec_pkg::*;

	logic [imm_width-1:0] imm;

	assign imm = instr[imm_width-1:0];

	always_comb begin
		case (ext_mode)
			ext_sign:  imm_value = {{(data_width-imm_width){imm[imm_width-1]}}, imm};
			ext_zero:  imm_value = {{(data_width-imm_width){1'b0}}, imm};
			// ALU does the 16-bit shift for LUI
			ext_upper: imm_value = {{(data_width-imm_width){1'b0}}, imm};
			default:   imm_value = {{(data_width-imm_width){1'b0}}, imm};
		endcase
	end

	assign operand_b = use_imm ? imm_value : rt_value;  // Second ALU operand

endmodule

//--- rtl/alu.sv
`timescale 1ns/100ps

module alu (
	input  logic [exec_pkg::data_width-1:0] a,
	input  logic [exec_pkg::data_width-1:0] b,
	input  exec_pkg::alu_op_t               operation,
	input  logic                            equal,      // BEQ when set, BNE when clear
	output logic [exec_pkg::data_width-1:0] result,
	output logic                            alu_zero    // Branch condition
);
	import exec_pkg::*;

	logic same;

	assign same = (a == b);

	always_comb begin
		alu_zero = 1'b0;
		result = 32'hdeadbeef;  // Marker for unsupported ops
		case (operation)
			alu_and:  result = a & b;
			alu_or:   result = a | b;
			alu_add:  result = $signed(a) + $signed(b);  // Wraps like ADDU
			alu_addu: result = a + b;
			alu_sub: begin
				result = $signed(a) - $signed(b);
				alu_zero = same ^ ~equal;  // Inverted sense for BNE
			end
			alu_subu: result = a - b;
			alu_bgez: begin
				if (!a[data_width-1]) begin  // rs non-negative
					result = 32'd1;
					alu_zero = 1'b1;
				end else begin
					result = '0;
				end
			end
			alu_slt: begin
				if ($signed(a) < $signed(b))
					result = 32'd1;
				else
					result = '0;
			end
			alu_nor:  result = ~(a | b);
			alu_xor:  result = a ^ b;
			alu_lui:  result = b << 16;  // Immediate to upper half
			alu_illegal: result = 32'hdeadbeef;
			default:  result = 32'hdeadbeef;
		endcase
	end

endmodule

//--- rtl/branch_unit.sv
`timescale 1ns/100ps

module branch_unit (
	input  logic [exec_pkg::data_width-1:0] pc,
	input  logic [exec_pkg::data_width-1:0] imm_value,     // Already sign-extended
	input  exec_pkg::branch_kind_t          branch_kind,
	input  logic                            alu_zero,
	output logic                            taken,
	output logic [exec_pkg::data_width-1:0] target,
	output logic [exec_pkg::data_width-1:0] link_address
);
	import exec_pkg::*;

	logic [data_width-1:0] pc_plus4;
	logic [data_width-1:0] offset;

	assign pc_plus4 = pc + 32'd4;  // Delay slot address
	assign offset = {imm_value[data_width-3:0], 2'b00};  // Word offset to bytes

	assign target = pc_plus4 + offset;
	assign link_address = pc + 32'd8;  // Return past the delay slot

	assign taken = (branch_kind != br_none) && alu_zero;

endmodule

//--- rtl/exec_writeback.sv
`timescale 1ns/100ps

module exec_writeback (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                in_valid,
	input  logic [exec_pkg::data_width-1:0]     alu_result,
	input  logic [exec_pkg::data_width-1:0]     link_address,
	input  exec_pkg::branch_kind_t              branch_kind,
	input  logic                                taken,
	input  logic [exec_pkg::data_width-1:0]     target,
	input  logic [exec_pkg::reg_addr_width-1:0] rt_addr,
	input  logic [exec_pkg::reg_addr_width-1:0] rd_addr,
	input  logic                                dest_is_rt,
	input  logic                                write_en_dec,
	input  logic                                illegal,
	output logic                                out_valid,
	output logic [exec_pkg::data_width-1:0]     result,
	output logic [exec_pkg::reg_addr_width-1:0] write_reg,
	output logic                                write_en,
	output logic                                branch_taken,
	output logic [exec_pkg::data_width-1:0]     branch_target,
	output logic                                illegal_out
);
	import exec_pkg::*;

	logic is_link;
	logic [data_width-1:0] result_sel;
	logic [reg_addr_width-1:0] dest_sel;

	assign is_link = (branch_kind == br_cond_link);  // BGEZAL path
	assign result_sel = is_link ? link_address : alu_result;
	assign dest_sel = is_link ? link_reg : (dest_is_rt ? rt_addr : rd_addr);

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			result <= '0;
			write_reg <= '0;
			write_en <= 1'b0;
			branch_taken <= 1'b0;
			branch_target <= '0;
			illegal_out <= 1'b0;
		end else begin
			out_valid <= in_valid;  // One-cycle strobe
			if (in_valid) begin  // Hold until next strobe
				result <= result_sel;
				write_reg <= dest_sel;
				write_en <= write_en_dec;
				branch_taken <= taken;
				branch_target <= target;
				illegal_out <= illegal;
			end
		end
	end

endmodule

//--- rtl/mips_execute.sv
`timescale 1ns/100ps

module mips_execute (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                in_valid,
	input  logic [31:0]                         instr,
	input  logic [exec_pkg::data_width-1:0]     rs_value,
	input  logic [exec_pkg::data_width-1:0]     rt_value,
	input  logic [exec_pkg::data_width-1:0]     pc,
	output logic                                out_valid,
	output logic [exec_pkg::data_width-1:0]     result,
	output logic [exec_pkg::reg_addr_width-1:0] write_reg,
	output logic                                write_en,
	output logic                                branch_taken,
	output logic [exec_pkg::data_width-1:0]     branch_target,
	output logic                                illegal
);
	import exec_pkg::*;

	alu_op_t alu_op;
	ext_mode_t ext_mode;
	branch_kind_t branch_kind;
	logic use_imm;
	logic equal;
	logic dest_is_rt;
	logic write_en_dec;
	logic illegal_dec;
	logic [data_width-1:0] imm_value;
	logic [data_width-1:0] operand_b;
	logic [data_width-1:0] alu_result;
	logic alu_zero;
	logic taken;
	logic [data_width-1:0] target;
	logic [data_width-1:0] link_address;

	exec_control exec_control_inst (
		.instr(instr), .alu_op(alu_op), .use_imm(use_imm), .ext_mode(ext_mode),
		.branch_kind(branch_kind), .equal(equal), .dest_is_rt(dest_is_rt),
		.write_en_dec(write_en_dec), .illegal(illegal_dec)
	);

	operand_extend operand_extend_inst (
		.instr(instr), .rt_value(rt_value), .ext_mode(ext_mode), .use_imm(use_imm),
		.imm_value(imm_value), .operand_b(operand_b)
	);

	alu alu_inst (
		.a(rs_value), .b(operand_b), .operation(alu_op), .equal(equal),
		.result(alu_result), .alu_zero(alu_zero)
	);

	branch_unit branch_unit_inst (
		.pc(pc), .imm_value(imm_value), .branch_kind(branch_kind), .alu_zero(alu_zero),
		.taken(taken), .target(target), .link_address(link_address)
	);

	exec_writeback exec_writeback_inst (
		.clk(clk), .reset(reset), .in_valid(in_valid), .alu_result(alu_result),
		.link_address(link_address), .branch_kind(branch_kind), .taken(taken),
		.target(target), .rt_addr(instr[20:16]), .rd_addr(instr[15:11]),
		.dest_is_rt(dest_is_rt), .write_en_dec(write_en_dec), .illegal(illegal_dec),
		.out_valid(out_valid), .result(result), .write_reg(write_reg),
		.write_en(write_en), .branch_taken(branch_taken),
		.branch_target(branch_target), .illegal_out(illegal)
	);

endmodule

//--- tb/mips_execute_asserts.sv
`timescale 1ns/100ps

module mips_execute_asserts (
	input logic        clk,
	input logic        reset,
	input logic        in_valid,
	input logic        out_valid,
	input logic [31:0] result,
	input logic        write_en,
	input logic        branch_taken,
	input logic        illegal
);

	// Result strobe trails the input strobe by exactly one cycle
	valid_follows: assert property (@(posedge clk) disable iff (reset) in_valid |=> out_valid)
		else $error("out_valid missing one cycle after in_valid");
	valid_only_on_strobe: assert property (@(posedge clk) disable iff (reset)
		!in_valid |=> !out_valid)
		else $error("out_valid raised without a strobe");

	quiet_after_reset: assert property (@(posedge clk)
		reset |=> !out_valid && !write_en && !branch_taken && !illegal && result == '0)
		else $error("outputs not cleared by reset");

	// Illegal encodings must stay inert
	illegal_inert: assert property (@(posedge clk) illegal |-> !write_en && !branch_taken)
		else $error("illegal instruction wrote or branched");

endmodule

bind mips_execute mips_execute_asserts mips_execute_asserts_inst (
	.clk(clk), .reset(reset), .in_valid(in_valid), .out_valid(out_valid),
	.result(result), .write_en(write_en), .branch_taken(branch_taken), .illegal(illegal)
);

//--- tb/tb_mips_execute.sv
`timescale 1ns/100ps

module tb_mips_execute;

	localparam int num_vectors = 27;
	localparam int fields = 10;      // Words per vector line
	localparam int wait_limit = 10;  // Cycles allowed for out_valid
	localparam int link_vector = 23; // BGEZAL taken, writes and branches

	logic clk;
	logic reset;
	logic in_valid;
	logic [31:0] instr;
	logic [31:0] rs_value;
	logic [31:0] rt_value;
	logic [31:0] pc;
	logic out_valid;
	logic [31:0] result;
	logic [4:0] write_reg;
	logic write_en;
	logic branch_taken;
	logic [31:0] branch_target;
	logic illegal;

	logic [31:0] vectors [0:num_vectors*fields-1];  // Flat, ten words per instruction
	int value_errors;
	int timeout_errors;

	mips_execute mips_execute_inst (.*);

	always #20 clk = ~clk;  // 40 ns period

	task automatic compare_field(input string name, input string where,
			input logic [31:0] got, input logic [31:0] expected);
		if (got !== expected) begin
			value_errors++;
			$display("error %s (%s): got %h expected %h", name, where, got, expected);
		end
	endtask

	task automatic apply_vector(input int idx);
		int base;
		base = idx * fields;
		instr = vectors[base];
		rs_value = vectors[base+1];
		rt_value = vectors[base+2];
		pc = vectors[base+3];
		in_valid = 1'b1;
	endtask

	// Samples on the falling edge, clear of the register update
	task automatic wait_out_valid(output bit seen);
		int cycles;
		seen = 1'b0;
		cycles = 0;
		while (!seen && cycles < wait_limit) begin
			@(negedge clk);
			cycles++;
			seen = out_valid;
		end
	endtask

	task automatic check_vector(input int idx);
		int base;
		bit seen;
		bit is_branch;
		string where;
		base = idx * fields;
		where = $sformatf("vector %0d", idx);
		wait_out_valid(seen);
		if (!seen) begin
			timeout_errors++;
			$display("out_valid did not arrive within %0d cycles for vector %0d",
				wait_limit, idx);
		end else begin
			is_branch = vectors[base][31:26] inside {6'h01, 6'h04, 6'h05};  // REGIMM, BEQ, BNE
			compare_field("write_en", where, {31'b0, write_en}, vectors[base+6]);
			compare_field("branch_taken", where, {31'b0, branch_taken}, vectors[base+7]);
			compare_field("illegal", where, {31'b0, illegal}, vectors[base+9]);
			if (vectors[base+6][0] || vectors[base+9][0])  // Result matters if written or illegal
				compare_field("result", where, result, vectors[base+4]);
			if (vectors[base+6][0])
				compare_field("write_reg", where, {27'b0, write_reg}, vectors[base+5]);
			if (is_branch && !vectors[base+9][0])
				compare_field("branch_target", where, branch_target, vectors[base+8]);
		end
	endtask

	task automatic check_reset_state();
		compare_field("out_valid", "after reset", {31'b0, out_valid}, 32'h0);
		compare_field("write_en", "after reset", {31'b0, write_en}, 32'h0);
		compare_field("branch_taken", "after reset", {31'b0, branch_taken}, 32'h0);
		compare_field("illegal", "after reset", {31'b0, illegal}, 32'h0);
		compare_field("result", "after reset", result, 32'h0);
		compare_field("write_reg", "after reset", {27'b0, write_reg}, 32'h0);
		compare_field("branch_target", "after reset", branch_target, 32'h0);
	endtask

	// Reset over a held result that has write_en and branch_taken set
	task automatic reset_over_result();
		@(posedge clk);
		#2;
		apply_vector(link_vector);
		@(posedge clk);
		#2;
		in_valid = 1'b0;
		check_vector(link_vector);
		@(posedge clk);
		#2;
		reset = 1'b1;
		repeat (8) @(posedge clk);
		#2;
		reset = 1'b0;
		@(negedge clk);
		check_reset_state();
	endtask

	// gap is the number of idle cycles between strobes
	task automatic run_pass(input int gap);
		fork
			begin
				for (int i = 0; i < num_vectors; i++) begin
					@(posedge clk);
					#2;
					apply_vector(i);
					for (int g = 0; g < gap; g++) begin
						@(posedge clk);
						#2;
						in_valid = 1'b0;
					end
				end
				@(posedge clk);
				#2;
				in_valid = 1'b0;
			end
			begin
				for (int j = 0; j < num_vectors; j++)
					check_vector(j);  // One result per strobe, in order
			end
		join
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		in_valid = 1'b0;
		instr = '0;
		rs_value = '0;
		rt_value = '0;
		pc = '0;
		value_errors = 0;
		timeout_errors = 0;
		$readmemh("tb/exec_vectors.txt", vectors);
		repeat (8) @(posedge clk);
		#2;
		reset = 1'b0;
		@(negedge clk);
		check_reset_state();
		run_pass(2);  // Spaced strobes
		reset_over_result();
		run_pass(0);  // Back-to-back strobes
		repeat (3) @(posedge clk);
		$display("value errors: %0d, timeouts: %0d", value_errors, timeout_errors);
		if (value_errors == 0 && timeout_errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

//--- tb/exec_vectors.txt
// instr rs_value rt_value pc | result write_reg write_en branch_taken branch_target illegal
// Unchecked fields hold 0: target off branches, result and write_reg when nothing is written
00221820 7fffffff 00000001 00400000 80000000 03 1 0 00000000 0
00221821 ffffffff 00000002 00400000 00000001 03 1 0 00000000 0
00221822 80000000 00000001 00400000 7fffffff 03 1 0 00000000 0
00221823 00000005 00000007 00400000 fffffffe 03 1 0 00000000 0
00221824 f0f0ff00 0ff00ff0 00400000 00f00f00 03 1 0 00000000 0
00221825 f0f0ff00 0ff00ff0 00400000 fff0fff0 03 1 0 00000000 0
00221826 f0f0ff00 0ff00ff0 00400000 ff00f0f0 03 1 0 00000000 0
00221827 f0f0ff00 0ff00ff0 00400000 000f000f 03 1 0 00000000 0
0022182a fffffffe 00000001 00400000 00000001 03 1 0 00000000 0
0022202a 00000001 fffffffe 00400000 00000000 04 1 0 00000000 0
2025fffc 00000010 00000000 00400000 0000000c 05 1 0 00000000 0
24258000 00000000 00000000 00400000 ffff8000 05 1 0 00000000 0
2825ffff fffffffe 00000000 00400000 00000001 05 1 0 00000000 0
3025ff00 1234abcd 00000000 00400000 0000ab00 05 1 0 00000000 0
34258001 12340000 00000000 00400000 12348001 05 1 0 00000000 0
3825ffff 0000f0f0 00000000 00400000 00000f0f 05 1 0 00000000 0
3c051234 deadbeef 00000000 00400000 12340000 05 1 0 00000000 0
10220004 00000055 00000055 00400000 00000000 00 0 1 00400014 0
1022fffc 00000001 00000002 00400100 00000000 00 0 0 004000f4 0
14220008 00000001 00000002 00400200 00000000 00 0 1 00400224 0
14220008 00000007 00000007 00400200 00000000 00 0 0 00400224 0
04200010 00000000 00000000 00400300 00000000 00 0 1 00400344 0
04200010 80000000 00000000 00400300 00000000 00 0 0 00400344 0
0431fff0 00000005 00000000 00400400 00400408 1f 1 1 004003c4 0
04310002 ffffffff 00000000 00400500 00400508 1f 1 0 0040050c 0
fc000000 00000000 00000000 00400600 deadbeef 00 0 0 00000000 1
00221801 00000003 00000004 00400600 deadbeef 00 0 0 00000000 1

//--- tb.f
rtl/exec_pkg.sv
rtl/exec_control.sv
rtl/operand_extend.sv
rtl/alu.sv
rtl/branch_unit.sv
rtl/exec_writeback.sv
rtl/mips_execute.sv
tb/mips_execute_asserts.sv
tb/tb_mips_execute.sv

//--- Makefile
TOP = tb_mips_execute

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f tb.f

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "ALL CHECKS PASSED"

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f tb.f

clean:
	rm -rf obj_dir
